// File: rtl/core_pkg.sv
`default_nettype none

package core_pkg;

  // ==================================================
  // Widths and vector types
  // ==================================================
  localparam int XLEN        = 32;
  localparam int REG_IDX_W   = 5;
  localparam int INSTR_BYTES = 4;

  typedef logic [XLEN-1:0]      word_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [2:0]           alu_op_t;
  typedef logic [1:0]           fwd_sel_t;

  // ==================================================
  // Instruction encodings
  // ==================================================
  // Major opcodes in instr[6:0]
  localparam logic [6:0] OPC_REG    = 7'b0110011;
  localparam logic [6:0] OPC_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  localparam logic [2:0] FUNCT3_BEQ = 3'b000;
  localparam logic [2:0] FUNCT3_BNE = 3'b001;

  // ==================================================
  // ALU operations and operand sources
  // ==================================================
  localparam alu_op_t ALU_ADD = 3'd0;
  localparam alu_op_t ALU_SUB = 3'd1;
  localparam alu_op_t ALU_AND = 3'd2;
  localparam alu_op_t ALU_OR  = 3'd3;
  localparam alu_op_t ALU_XOR = 3'd4;
  localparam alu_op_t ALU_SLT = 3'd5;

  // Where an execute operand comes from
  localparam fwd_sel_t FWD_NONE = 2'd0;
  localparam fwd_sel_t FWD_MEM  = 2'd1;
  localparam fwd_sel_t FWD_WB   = 2'd2;

endpackage

`default_nettype wire

// File: rtl/hazard_unit.sv
`default_nettype none

module hazard_unit (
  input  core_pkg::reg_idx_t id_rs1_i,
  input  core_pkg::reg_idx_t id_rs2_i,
  input  core_pkg::reg_idx_t ex_rs1_i,
  input  core_pkg::reg_idx_t ex_rs2_i,
  input  core_pkg::reg_idx_t ex_rd_i,
  input  core_pkg::reg_idx_t mem_rd_i,
  input  core_pkg::reg_idx_t wb_rd_i,
  input  logic               ex_mem_read_i,
  input  logic               mem_reg_write_i,
  input  logic               wb_reg_write_i,
  input  logic               branch_taken_i,
  output logic               stall_o,
  output logic               flush_o,
  output core_pkg::fwd_sel_t fwd_a_sel_o,
  output core_pkg::fwd_sel_t fwd_b_sel_o
);
  import core_pkg::*;

  logic load_use;

  // Nearest older write wins, so the memory stage overrides writeback.
  // Writes to x0 never carry an enable, so index zero cannot match.
  function automatic fwd_sel_t fwd_pick(input reg_idx_t src);
    fwd_sel_t sel;
    sel = FWD_NONE;
    if (wb_reg_write_i && (wb_rd_i == src)) begin
      sel = FWD_WB;
    end
    if (mem_reg_write_i && (mem_rd_i == src)) begin
      sel = FWD_MEM;
    end
    return sel;
  endfunction

  always_comb begin
    fwd_a_sel_o = fwd_pick(ex_rs1_i);
    fwd_b_sel_o = fwd_pick(ex_rs2_i);
  end

  // ==================================================
  // Load-use stall and branch flush
  // ==================================================
  // Load data only exists after the memory stage
  assign load_use = ex_mem_read_i && (ex_rd_i != '0) &&
                    ((ex_rd_i == id_rs1_i) || (ex_rd_i == id_rs2_i));

  // Flush has priority
  assign stall_o = load_use && !branch_taken_i;
  assign flush_o = branch_taken_i;

endmodule

`default_nettype wire

// File: rtl/fetch_stage.sv
`default_nettype none

module fetch_stage #(
  parameter core_pkg::word_t RESET_PC = '0
) (
  input  logic            clk_i,
  input  logic            rst_i,
  input  core_pkg::word_t imem_data_i,
  input  logic            stall_i,
  input  logic            flush_i,
  input  core_pkg::word_t branch_target_i,
  output core_pkg::word_t imem_addr_o,
  output core_pkg::word_t if_pc_o,
  output core_pkg::word_t if_instr_o,
  output logic            if_valid_o
);
  import core_pkg::*;

  word_t pc;

  assign imem_addr_o = pc;

  // Not-taken prediction keeps the pc sequential until execute redirects
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pc <= RESET_PC;
    end else if (flush_i) begin
      pc <= branch_target_i;
    end else if (!stall_i) begin
      pc <= pc + word_t'(INSTR_BYTES);
    end
  end

  // IF/ID valid bit
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      if_valid_o <= 1'b0;
    end else if (!stall_i) begin
      if_valid_o <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      if_pc_o    <= pc;
      if_instr_o <= imem_data_i;
    end
  end

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
`default_nettype none

module decode_stage (
  input  logic               clk_i,
  input  logic               rst_i,
  input  core_pkg::word_t    if_pc_i,
  input  core_pkg::word_t    if_instr_i,
  input  logic               if_valid_i,
  input  logic               stall_i,
  input  logic               flush_i,
  input  logic               wb_reg_write_i,
  input  core_pkg::reg_idx_t wb_rd_i,
  input  core_pkg::word_t    wb_data_i,
  output core_pkg::reg_idx_t id_rs1_o,
  output core_pkg::reg_idx_t id_rs2_o,
  output core_pkg::reg_idx_t ex_rs1_o,
  output core_pkg::reg_idx_t ex_rs2_o,
  output core_pkg::reg_idx_t ex_rd_o,
  output core_pkg::word_t    ex_pc_o,
  output core_pkg::word_t    ex_a_o,
  output core_pkg::word_t    ex_b_o,
  output core_pkg::word_t    ex_imm_o,
  output core_pkg::alu_op_t  ex_alu_op_o,
  output logic               ex_use_imm_o,
  output logic               ex_reg_write_o,
  output logic               ex_mem_read_o,
  output logic               ex_mem_write_o,
  output logic               ex_branch_o,
  output logic               ex_branch_ne_o
);
  import core_pkg::*;

  word_t      regs [32];
  logic [6:0] opcode;
  logic [6:0] funct7;
  logic [2:0] funct3;
  reg_idx_t   rd;
  word_t      imm;
  alu_op_t    alu_op;
  logic       use_imm;
  logic       reg_write;
  logic       mem_read;
  logic       mem_write;
  logic       branch;

  assign opcode   = if_instr_i[6:0];
  assign rd       = if_instr_i[11:7];
  assign funct3   = if_instr_i[14:12];
  assign funct7   = if_instr_i[31:25];
  assign id_rs1_o = if_instr_i[19:15];
  assign id_rs2_o = if_instr_i[24:20];

  // ==================================================
  // Decoder and immediates
  // ==================================================
  always_comb begin
    alu_op    = ALU_ADD;
    imm       = '0;
    use_imm   = 1'b0;
    reg_write = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    branch    = 1'b0;
    if (if_valid_i) begin
      case (opcode)
        OPC_REG: begin
          reg_write = 1'b1;
          case (funct3)
            3'b000:  alu_op = if_instr_i[30] ? ALU_SUB : ALU_ADD;
            3'b111:  alu_op = ALU_AND;
            3'b110:  alu_op = ALU_OR;
            3'b100:  alu_op = ALU_XOR;
            3'b010:  alu_op = ALU_SLT;
            default: reg_write = 1'b0;
          endcase
          // Only SUB may set funct7[5]
          if ((funct7 != 7'b0) && !((funct7 == 7'b0100000) && (funct3 == 3'b000))) begin
            reg_write = 1'b0;
          end
        end
        OPC_IMM: begin
          // ADDI only
          reg_write = (funct3 == 3'b000);
          use_imm   = 1'b1;
          imm       = {{20{if_instr_i[31]}}, if_instr_i[31:20]};
        end
        OPC_LOAD: begin
          reg_write = (funct3 == 3'b010);
          mem_read  = (funct3 == 3'b010);
          use_imm   = 1'b1;
          imm       = {{20{if_instr_i[31]}}, if_instr_i[31:20]};
        end
        OPC_STORE: begin
          mem_write = (funct3 == 3'b010);
          use_imm   = 1'b1;
          imm       = {{20{if_instr_i[31]}}, if_instr_i[31:25], if_instr_i[11:7]};
        end
        OPC_BRANCH: begin
          branch = (funct3 == FUNCT3_BEQ) || (funct3 == FUNCT3_BNE);
          imm    = {{19{if_instr_i[31]}}, if_instr_i[31], if_instr_i[7],
                    if_instr_i[30:25], if_instr_i[11:8], 1'b0};
        end
        default: ;
      endcase
      if (rd == '0) begin
        reg_write = 1'b0;
      end
    end
  end

  // ==================================================
  // Write-through register file
  // ==================================================
  function automatic word_t rf_read(input reg_idx_t idx);
    if (idx == '0) begin
      return '0;
    end
    if (wb_reg_write_i && (wb_rd_i == idx)) begin
      return wb_data_i;
    end
    return regs[idx];
  endfunction

  always_ff @(posedge clk_i) begin
    if (wb_reg_write_i && (wb_rd_i != '0)) begin
      regs[wb_rd_i] <= wb_data_i;
    end
  end

  // ID/EX control takes a bubble on stall or flush
  always_ff @(posedge clk_i) begin
    if (rst_i || stall_i || flush_i) begin
      ex_reg_write_o <= 1'b0;
      ex_mem_read_o  <= 1'b0;
      ex_mem_write_o <= 1'b0;
      ex_branch_o    <= 1'b0;
    end else begin
      ex_reg_write_o <= reg_write;
      ex_mem_read_o  <= mem_read;
      ex_mem_write_o <= mem_write;
      ex_branch_o    <= branch;
    end
  end

  always_ff @(posedge clk_i) begin
    ex_rs1_o       <= id_rs1_o;
    ex_rs2_o       <= id_rs2_o;
    ex_rd_o        <= rd;
    ex_pc_o        <= if_pc_i;
    ex_a_o         <= rf_read(id_rs1_o);
    ex_b_o         <= rf_read(id_rs2_o);
    ex_imm_o       <= imm;
    ex_alu_op_o    <= alu_op;
    ex_use_imm_o   <= use_imm;
    ex_branch_ne_o <= (funct3 == FUNCT3_BNE);
  end

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
`default_nettype none

module execute_stage (
  input  logic               clk_i,
  input  logic               rst_i,
  input  core_pkg::word_t    ex_pc_i,
  input  core_pkg::word_t    ex_a_i,
  input  core_pkg::word_t    ex_b_i,
  input  core_pkg::word_t    ex_imm_i,
  input  core_pkg::reg_idx_t ex_rd_i,
  input  core_pkg::alu_op_t  ex_alu_op_i,
  input  logic               ex_use_imm_i,
  input  logic               ex_reg_write_i,
  input  logic               ex_mem_read_i,
  input  logic               ex_mem_write_i,
  input  logic               ex_branch_i,
  input  logic               ex_branch_ne_i,
  input  core_pkg::fwd_sel_t fwd_a_sel_i,
  input  core_pkg::fwd_sel_t fwd_b_sel_i,
  input  core_pkg::word_t    mem_fwd_data_i,
  input  core_pkg::word_t    wb_fwd_data_i,
  output logic               branch_taken_o,
  output core_pkg::word_t    branch_target_o,
  output core_pkg::word_t    mem_result_o,
  output core_pkg::word_t    mem_store_data_o,
  output core_pkg::reg_idx_t mem_rd_o,
  output logic               mem_reg_write_o,
  output logic               mem_mem_read_o,
  output logic               mem_mem_write_o
);
  import core_pkg::*;

  word_t op_a;
  word_t rs2_val;
  word_t op_b;
  word_t alu_result;

  function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t reg_val);
    case (sel)
      FWD_MEM: return mem_fwd_data_i;
      FWD_WB:  return wb_fwd_data_i;
      default: return reg_val;
    endcase
  endfunction

  always_comb begin
    op_a    = fwd_mux(fwd_a_sel_i, ex_a_i);
    rs2_val = fwd_mux(fwd_b_sel_i, ex_b_i);
  end

  assign op_b = ex_use_imm_i ? ex_imm_i : rs2_val;

  always_comb begin
    case (ex_alu_op_i)
      ALU_ADD: alu_result = op_a + op_b;
      ALU_SUB: alu_result = op_a - op_b;
      ALU_AND: alu_result = op_a & op_b;
      ALU_OR:  alu_result = op_a | op_b;
      ALU_XOR: alu_result = op_a ^ op_b;
      ALU_SLT: alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      default: alu_result = '0;
    endcase
  end

  // BEQ/BNE resolve here and redirect to pc + B immediate
  assign branch_taken_o  = ex_branch_i && ((op_a == rs2_val) != ex_branch_ne_i);
  assign branch_target_o = ex_pc_i + ex_imm_i;

  // EX/MEM
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mem_reg_write_o <= 1'b0;
      mem_mem_read_o  <= 1'b0;
      mem_mem_write_o <= 1'b0;
    end else begin
      mem_reg_write_o <= ex_reg_write_i;
      mem_mem_read_o  <= ex_mem_read_i;
      mem_mem_write_o <= ex_mem_write_i;
    end
  end

  always_ff @(posedge clk_i) begin
    mem_result_o     <= alu_result;
    mem_store_data_o <= rs2_val;
    mem_rd_o         <= ex_rd_i;
  end

endmodule

`default_nettype wire

// File: rtl/memory_stage.sv
`default_nettype none

module memory_stage #(
  parameter int DMEM_WORDS = 64
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  core_pkg::word_t    mem_result_i,
  input  core_pkg::word_t    mem_store_data_i,
  input  core_pkg::reg_idx_t mem_rd_i,
  input  logic               mem_reg_write_i,
  input  logic               mem_mem_read_i,
  input  logic               mem_mem_write_i,
  output logic               wb_reg_write_o,
  output core_pkg::reg_idx_t wb_rd_o,
  output core_pkg::word_t    wb_data_o
);
  import core_pkg::*;

  localparam int IDX_W = $clog2(DMEM_WORDS);

  word_t            dmem [DMEM_WORDS];
  logic [IDX_W-1:0] word_idx;
  word_t            load_data;

  // Word addressing ignores the byte offset
  assign word_idx  = mem_result_i[IDX_W+1:2];
  assign load_data = dmem[word_idx];

  always_ff @(posedge clk_i) begin
    if (mem_mem_write_i) begin
      dmem[word_idx] <= mem_store_data_i;
    end
  end

  // MEM/WB
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wb_reg_write_o <= 1'b0;
    end else begin
      wb_reg_write_o <= mem_reg_write_i;
    end
  end

  always_ff @(posedge clk_i) begin
    wb_rd_o   <= mem_rd_i;
    wb_data_o <= mem_mem_read_i ? load_data : mem_result_i;
  end

endmodule

`default_nettype wire

// File: rtl/core_top.sv
`default_nettype none

module core_top #(
  parameter core_pkg::word_t RESET_PC   = '0,
  parameter int              DMEM_WORDS = 64
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  core_pkg::word_t    imem_data_i,
  output core_pkg::word_t    imem_addr_o,
  output logic               wb_valid_o,
  output core_pkg::reg_idx_t wb_rd_o,
  output core_pkg::word_t    wb_data_o
);
  import core_pkg::*;

  // Fetch to decode
  word_t    if_pc;
  word_t    if_instr;
  logic     if_valid;

  // Hazard control
  logic     stall;
  logic     flush;
  fwd_sel_t fwd_a_sel;
  fwd_sel_t fwd_b_sel;

  // ID/EX contents
  reg_idx_t id_rs1;
  reg_idx_t id_rs2;
  reg_idx_t ex_rs1;
  reg_idx_t ex_rs2;
  reg_idx_t ex_rd;
  word_t    ex_pc;
  word_t    ex_a;
  word_t    ex_b;
  word_t    ex_imm;
  alu_op_t  ex_alu_op;
  logic     ex_use_imm;
  logic     ex_reg_write;
  logic     ex_mem_read;
  logic     ex_mem_write;
  logic     ex_branch;
  logic     ex_branch_ne;

  // Branch resolution and EX/MEM contents
  logic     branch_taken;
  word_t    branch_target;
  word_t    mem_result;
  word_t    mem_store_data;
  reg_idx_t mem_rd;
  logic     mem_reg_write;
  logic     mem_mem_read;
  logic     mem_mem_write;

  fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
    .clk_i(clk_i), .rst_i(rst_i), .imem_data_i(imem_data_i),
    .stall_i(stall), .flush_i(flush), .branch_target_i(branch_target),
    .imem_addr_o(imem_addr_o), .if_pc_o(if_pc), .if_instr_o(if_instr), .if_valid_o(if_valid)
  );

  decode_stage u_decode (
    .clk_i(clk_i), .rst_i(rst_i),
    .if_pc_i(if_pc), .if_instr_i(if_instr), .if_valid_i(if_valid),
    .stall_i(stall), .flush_i(flush),
    .wb_reg_write_i(wb_valid_o), .wb_rd_i(wb_rd_o), .wb_data_i(wb_data_o),
    .id_rs1_o(id_rs1), .id_rs2_o(id_rs2),
    .ex_rs1_o(ex_rs1), .ex_rs2_o(ex_rs2), .ex_rd_o(ex_rd),
    .ex_pc_o(ex_pc), .ex_a_o(ex_a), .ex_b_o(ex_b), .ex_imm_o(ex_imm),
    .ex_alu_op_o(ex_alu_op), .ex_use_imm_o(ex_use_imm), .ex_reg_write_o(ex_reg_write),
    .ex_mem_read_o(ex_mem_read), .ex_mem_write_o(ex_mem_write),
    .ex_branch_o(ex_branch), .ex_branch_ne_o(ex_branch_ne)
  );

  execute_stage u_execute (
    .clk_i(clk_i), .rst_i(rst_i),
    .ex_pc_i(ex_pc), .ex_a_i(ex_a), .ex_b_i(ex_b), .ex_imm_i(ex_imm), .ex_rd_i(ex_rd),
    .ex_alu_op_i(ex_alu_op), .ex_use_imm_i(ex_use_imm), .ex_reg_write_i(ex_reg_write),
    .ex_mem_read_i(ex_mem_read), .ex_mem_write_i(ex_mem_write),
    .ex_branch_i(ex_branch), .ex_branch_ne_i(ex_branch_ne),
    .fwd_a_sel_i(fwd_a_sel), .fwd_b_sel_i(fwd_b_sel),
    .mem_fwd_data_i(mem_result), .wb_fwd_data_i(wb_data_o),
    .branch_taken_o(branch_taken), .branch_target_o(branch_target),
    .mem_result_o(mem_result), .mem_store_data_o(mem_store_data), .mem_rd_o(mem_rd),
    .mem_reg_write_o(mem_reg_write), .mem_mem_read_o(mem_mem_read),
    .mem_mem_write_o(mem_mem_write)
  );

  memory_stage #(.DMEM_WORDS(DMEM_WORDS)) u_memory (
    .clk_i(clk_i), .rst_i(rst_i),
    .mem_result_i(mem_result), .mem_store_data_i(mem_store_data), .mem_rd_i(mem_rd),
    .mem_reg_write_i(mem_reg_write), .mem_mem_read_i(mem_mem_read),
    .mem_mem_write_i(mem_mem_write),
    .wb_reg_write_o(wb_valid_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o)
  );

  hazard_unit u_hazard (
    .id_rs1_i(id_rs1), .id_rs2_i(id_rs2), .ex_rs1_i(ex_rs1), .ex_rs2_i(ex_rs2),
    .ex_rd_i(ex_rd), .mem_rd_i(mem_rd), .wb_rd_i(wb_rd_o),
    .ex_mem_read_i(ex_mem_read), .mem_reg_write_i(mem_reg_write),
    .wb_reg_write_i(wb_valid_o), .branch_taken_i(branch_taken),
    .stall_o(stall), .flush_o(flush), .fwd_a_sel_o(fwd_a_sel), .fwd_b_sel_o(fwd_b_sel)
  );

endmodule

`default_nettype wire

// File: testbench/clock_gen.sv
`default_nettype none

module clock_gen #(
  parameter int HALF_PERIOD_NS = 10,
  parameter int RESET_CYCLES   = 8,
  parameter int DRIVE_NS       = 2
) (
  output logic clk_o,
  output logic rst_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  // Release reset just after an edge, like any other stimulus
  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #(DRIVE_NS);
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

// File: testbench/core_properties.sv
`default_nettype none

module core_properties (
  input logic               clk_i,
  input logic               rst_i,
  input core_pkg::word_t    imem_addr_i,
  input logic               wb_valid_i,
  input core_pkg::reg_idx_t wb_rd_i
);
  timeunit 1ns;
  timeprecision 100ps;
  import core_pkg::*;

  int failures = 0;

  // Pipeline registers clear on the first reset edge
  reset_quiet: assert property (@(posedge clk_i) rst_i |=> !wb_valid_i)
    else begin
      failures++;
      $error("wb_valid_o is high while the core is in reset");
    end

  addr_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
    (imem_addr_i % INSTR_BYTES) == 0)
    else begin
      failures++;
      $error("imem_addr_o 0x%08h is not word aligned", imem_addr_i);
    end

  // x0 writes are dropped in decode
  no_x0_write: assert property (@(posedge clk_i) disable iff (rst_i)
    wb_valid_i |-> (wb_rd_i != '0))
    else begin
      failures++;
      $error("register write reported for x0");
    end

endmodule

bind core_top core_properties u_props (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .imem_addr_i(imem_addr_o),
  .wb_valid_i (wb_valid_o),
  .wb_rd_i    (wb_rd_o)
);

`default_nettype wire

// File: testbench/core_tb.sv
`default_nettype none

module core_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import core_pkg::*;

  localparam int          CLK_NS          = 20;
  localparam int          RESET_CYCLES    = 8;
  localparam int          DRIVE_NS        = 2;
  localparam int          IMEM_WORDS      = 64;
  localparam int          CYCLES_PER_WORD = 8;
  localparam logic [31:0] RNG_SEED        = 32'h8449_4794;
  localparam word_t       NOP_WORD        = 32'h0000_0013;
  localparam string       PATTERN_FILE    = "testbench/core_patterns.txt";

  logic     clk;
  logic     rst;
  word_t    imem_data;
  word_t    imem_addr;
  logic     wb_valid;
  reg_idx_t wb_rd;
  word_t    wb_data;

  word_t    program_mem [IMEM_WORDS];
  reg_idx_t exp_rd [$];
  word_t    exp_data [$];
  int       prog_words  = 0;
  int       writes_seen = 0;
  int       check_count = 0;
  int       error_count = 0;
  int       idle_cycles = 0;
  bit       loaded      = 1'b0;

  clock_gen #(
    .HALF_PERIOD_NS(CLK_NS / 2),
    .RESET_CYCLES  (RESET_CYCLES),
    .DRIVE_NS      (DRIVE_NS)
  ) u_clock (
    .clk_o(clk),
    .rst_o(rst)
  );

  core_top #(
    .RESET_PC  (32'h0000_0000),
    .DMEM_WORDS(64)
  ) dut (
    .clk_i      (clk),
    .rst_i      (rst),
    .imem_data_i(imem_data),
    .imem_addr_o(imem_addr),
    .wb_valid_o (wb_valid),
    .wb_rd_o    (wb_rd),
    .wb_data_o  (wb_data)
  );

  // ==================================================
  // Pattern loading and instruction memory
  // ==================================================
  task automatic load_patterns();
    int    fd;
    int    n;
    int    rd_val;
    byte   tag;
    word_t value;
    string line;
    // Unused words are addi x31, x0, index so a missed flush shows up as a write
    foreach (program_mem[i]) begin
      program_mem[i] = {12'(i), 5'd0, 3'b000, 5'd31, 7'b0010011};
    end
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open the pattern file %s", PATTERN_FILE);
      error_count++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if ($sscanf(line, "%c", tag) != 1) begin
        continue;
      end
      if (tag == "I") begin
        n = $sscanf(line, "%c %h", tag, value);
        if (n == 2 && prog_words < IMEM_WORDS) begin
          program_mem[prog_words] = value;
          prog_words++;
        end else begin
          $display("Bad or surplus program line in the pattern file: %s", line);
          error_count++;
        end
      end else if (tag == "W") begin
        n = $sscanf(line, "%c %d %h", tag, rd_val, value);
        if (n == 3) begin
          exp_rd.push_back(reg_idx_t'(rd_val));
          exp_data.push_back(value);
        end else begin
          $display("Bad register write line in the pattern file: %s", line);
          error_count++;
        end
      end
    end
    $fclose(fd);
  endtask

  function automatic word_t fetch_word(input word_t addr);
    word_t idx;
    idx = addr >> 2;
    if (idx < IMEM_WORDS) begin
      return program_mem[idx];
    end else begin
      return NOP_WORD;
    end
  endfunction

  // Serve the word for the current pc shortly after each edge
  always @(posedge clk) begin
    #(DRIVE_NS);
    imem_data = fetch_word(imem_addr);
  end

  // ==================================================
  // Writeback checking
  // ==================================================
  task automatic check_write(input reg_idx_t rd, input word_t data);
    assert (writes_seen < exp_rd.size()) else begin
      error_count++;
      $display("Register write to x%0d at %0t ns came after the last expected write",
               rd, $time);
    end
    if (writes_seen < exp_rd.size()) begin
      check_count++;
      assert (rd == exp_rd[writes_seen]) else begin
        error_count++;
        $display("error at %0t ns: wb_rd_o = %0d, expected %0d",
                 $time, rd, exp_rd[writes_seen]);
      end
      assert (data === exp_data[writes_seen]) else begin
        error_count++;
        $display("error at %0t ns: wb_data_o = 0x%08h, expected 0x%08h",
                 $time, data, exp_data[writes_seen]);
      end
      writes_seen++;
    end
  endtask

  // Sample mid-cycle where outputs have settled
  always @(negedge clk) begin
    if (!rst && wb_valid) begin
      check_write(wb_rd, wb_data);
    end
  end

  task automatic report_and_finish();
    int prop_failures;
    prop_failures = dut.u_props.failures;
    $display("Summary: %0d checks, %0d errors, %0d assertion failures, %0d of %0d writes",
             check_count, error_count, prop_failures, writes_seen, exp_rd.size());
    if (error_count == 0 && prop_failures == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  // ==================================================
  // Main sequence and watchdog
  // ==================================================
  initial begin
    imem_data = NOP_WORD;
    void'($urandom(RNG_SEED));
    load_patterns();
    loaded = 1'b1;
    if (exp_rd.size() == 0) begin
      $display("The pattern file holds no expected register writes");
      error_count++;
    end else begin
      @(negedge rst);
      wait (writes_seen >= exp_rd.size());
      // Self-loop must stay quiet
      idle_cycles = $urandom_range(40, 16);
      repeat (idle_cycles) @(posedge clk);
      @(negedge clk);
    end
    report_and_finish();
  end

  initial begin : watchdog
    int timeout_ns;
    wait (loaded);
    timeout_ns = (CYCLES_PER_WORD * prog_words + RESET_CYCLES) * CLK_NS;
    #(timeout_ns);
    $display("Timeout after %0d ns: %0d of %0d expected register writes were missing",
             timeout_ns, exp_rd.size() - writes_seen, exp_rd.size());
    error_count++;
    report_and_finish();
  end

endmodule

`default_nettype wire

// File: testbench/core_patterns.txt
# I <instruction word, hex>     program words in address order
# W <rd, decimal> <value, hex>  expected register writes in program order
I 00500093  # addi x1, x0, 5
I FFD00113  # addi x2, x0, -3
I 00C00193  # addi x3, x0, 12
I 00208233  # add  x4, x1, x2
I 403082B3  # sub  x5, x1, x3
I 0011F333  # and  x6, x3, x1
I 0011E3B3  # or   x7, x3, x1
I 0011C433  # xor  x8, x3, x1
I 001124B3  # slt  x9, x2, x1
W 1 00000005
W 2 FFFFFFFD
W 3 0000000C
W 4 00000002
W 5 FFFFFFF9
W 6 00000004
W 7 0000000D
W 8 00000009
W 9 00000001
# Forwarding at distances one, two and three
I 06400513  # addi x10, x0, 100
I 00A505B3  # add  x11, x10, x10
I 40A58633  # sub  x12, x11, x10
I 00B546B3  # xor  x13, x10, x11
I 00100713  # addi x14, x0, 1
I 00270713  # addi x14, x14, 2
I 00E707B3  # add  x15, x14, x14
W 10 00000064
W 11 000000C8
W 12 00000064
W 13 000000AC
W 14 00000001
W 14 00000003
W 15 00000006
# Store, load and load-use
I 04000813  # addi x16, x0, 64
I 00A82423  # sw   x10, 8(x16)
I 00882883  # lw   x17, 8(x16)
I 00188933  # add  x18, x17, x1
W 16 00000040
W 17 00000064
W 18 00000069
# Untaken BEQ and BNE
I 00208463  # beq  x1, x2, +8
I 00700993  # addi x19, x0, 7
I 00109463  # bne  x1, x1, +8
I 00900A13  # addi x20, x0, 9
W 19 00000007
W 20 00000009
# Taken BEQ and BNE, two shadow writes each
I 00C50663  # beq  x10, x12, +12
I 3AD00A93  # addi x21, x0, 0x3ad
I 3AE00B13  # addi x22, x0, 0x3ae
I 00B00A93  # addi x21, x0, 11
I 001A9663  # bne  x21, x1, +12
I 3AD00B93  # addi x23, x0, 0x3ad
I 3AE00C13  # addi x24, x0, 0x3ae
I 00D00B93  # addi x23, x0, 13
I 015B8C33  # add  x24, x23, x21
I 00000063  # beq  x0, x0, 0
W 21 0000000B
W 23 0000000D
W 24 00000018

// File: all.f
rtl/core_pkg.sv
rtl/hazard_unit.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/core_top.sv
testbench/clock_gen.sv
testbench/core_properties.sv
testbench/core_tb.sv

// File: Bender.yml
package:
  name: rv32i_core

sources:
  - rtl/core_pkg.sv
  - rtl/hazard_unit.sv
  - rtl/fetch_stage.sv
  - rtl/decode_stage.sv
  - rtl/execute_stage.sv
  - rtl/memory_stage.sv
  - rtl/core_top.sv
  - target: simulation
    files:
      - testbench/clock_gen.sv
      - testbench/core_properties.sv
      - testbench/core_tb.sv
